//--- mpu_pkg.sv
`default_nettype none

package mpu_pkg;

  ////////////////////
  // Widths
  ////////////////////

  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;

  ////////////////////
  // Enums
  ////////////////////

  // Access kind as seen by the PMP
  typedef enum logic [1:0] {
    PMP_ACC_EXEC  = 2'b00,
    PMP_ACC_READ  = 2'b01,
    PMP_ACC_WRITE = 2'b10
  } pmp_acc_e;

  // RISC-V privilege encodings, only U and M exist here
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } privlvl_e;

  // A field of pmpcfg, NA4 (2'b10) not supported
  typedef enum logic [1:0] {
    PMP_OFF   = 2'b00,
    PMP_TOR   = 2'b01,
    PMP_NAPOT = 2'b11
  } pmp_mode_e;

  // Error consuming FSM
  typedef enum logic [2:0] {
    MPU_IDLE,
    MPU_RE_ERR_WAIT,
    MPU_WR_ERR_WAIT,
    MPU_RE_ERR_RESP,
    MPU_WR_ERR_RESP
  } mpu_state_e;

  // Status returned with every core response
  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  ////////////////////
  // PMA region map
  ////////////////////

  parameter int PMA_NUM_REGIONS = 3;

  // Index 0 RAM, index 1 I/O, index 2 ROM
  parameter logic [PMA_NUM_REGIONS-1:0][ADDR_W-1:0] PMA_BASE =
    {32'h2000_0000, 32'h1000_0000, 32'h0000_0000};

  // Address bits that must equal the base
  parameter logic [PMA_NUM_REGIONS-1:0][ADDR_W-1:0] PMA_MASK =
    {32'hFFFF_0000, 32'hFFFF_F000, 32'hFFFF_0000};

  parameter logic [PMA_NUM_REGIONS-1:0] PMA_MAIN       = 3'b101;
  parameter logic [PMA_NUM_REGIONS-1:0] PMA_BUFFERABLE = 3'b011;
  parameter logic [PMA_NUM_REGIONS-1:0] PMA_CACHEABLE  = 3'b101;

endpackage

`default_nettype wire

//--- mpu_check_if.sv
`timescale 1ns/100ps
`default_nettype none

interface mpu_check_if #(
  parameter int PMP_NUM_REGIONS = 4
);

  // Request side, driven from the control module
  logic [mpu_pkg::ADDR_W-1:0] addr;
  mpu_pkg::pmp_acc_e          acc;
  logic                       misaligned;
  mpu_pkg::privlvl_e          priv_lvl;

  // Results from the two checkers
  logic                       pma_err;
  logic                       pmp_err;
  logic                       bufferable;
  logic                       cacheable;

  modport ctrl (
    output addr, acc, misaligned, priv_lvl,
    input  pma_err, pmp_err, bufferable, cacheable
  );

  modport pma (
    input  addr, acc, misaligned,
    output pma_err, bufferable, cacheable
  );

  modport pmp (
    input  addr, acc, priv_lvl,
    output pmp_err
  );

endinterface

`default_nettype wire

//--- mpu_pma_check.sv
`timescale 1ns/100ps
`default_nettype none

module mpu_pma_check (
  mpu_check_if.pma chk
);

  // ROM entry of the map, write protected
  localparam int ROM_REGION = 2;

  logic [mpu_pkg::PMA_NUM_REGIONS-1:0] region_hit;
  logic                                hit;
  logic                                hit_main;
  logic                                hit_buf;
  logic                                hit_cache;
  logic                                hit_rom;

  // Compare address against each fixed region
  for (genvar i = 0; i < mpu_pkg::PMA_NUM_REGIONS; i++) begin : g_hit
    assign region_hit[i] =
      (chk.addr & mpu_pkg::PMA_MASK[i]) == mpu_pkg::PMA_BASE[i];
  end

  // Lowest index wins, regions do not overlap anyway
  always_comb begin
    hit       = 1'b0;
    hit_main  = 1'b0;
    hit_buf   = 1'b0;
    hit_cache = 1'b0;
    hit_rom   = 1'b0;
    for (int i = mpu_pkg::PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (region_hit[i]) begin
        hit       = 1'b1;
        hit_main  = mpu_pkg::PMA_MAIN[i];
        hit_buf   = mpu_pkg::PMA_BUFFERABLE[i];
        hit_cache = mpu_pkg::PMA_CACHEABLE[i];
        hit_rom   = (i == ROM_REGION);
      end
    end
  end

  ////////////////////
  // Results
  ////////////////////

  // Unmapped, misaligned to I/O or write to ROM
  assign chk.pma_err = !hit ||
                       (chk.misaligned && !hit_main) ||
                       (hit_rom && (chk.acc == mpu_pkg::PMP_ACC_WRITE));

  // Zero on a miss since all hit_* stay low
  assign chk.bufferable = hit_buf;
  assign chk.cacheable  = hit_cache;

endmodule

`default_nettype wire

//--- mpu_pmp_check.sv
`timescale 1ns/100ps
`default_nettype none

module mpu_pmp_check #(
  parameter int PMP_NUM_REGIONS = 4
) (
  mpu_check_if.pmp                                 chk,
  input  wire logic [8*PMP_NUM_REGIONS-1:0]        pmp_cfg_i,
  input  wire logic [32*PMP_NUM_REGIONS-1:0]       pmp_addr_i
);

  // Request address on the 34-bit physical scale
  logic [33:0]                req_addr;
  logic [PMP_NUM_REGIONS-1:0] region_match;
  logic [PMP_NUM_REGIONS-1:0] region_perm;
  logic [PMP_NUM_REGIONS-1:0] region_lock;
  logic                       hit;
  logic                       hit_perm;
  logic                       hit_lock;

  assign req_addr = {2'b00, chk.addr};

  ////////////////////
  // Per region match
  ////////////////////

  for (genvar i = 0; i < PMP_NUM_REGIONS; i++) begin : g_region
    logic [7:0]          cfg;
    mpu_pkg::pmp_mode_e  mode;
    logic [31:0]         addr_cur;
    logic [31:0]         addr_prev;
    logic [31:0]         napot_mask;
    logic                tor_match;
    logic                napot_match;

    // Config byte L..A.X.W.R
    assign cfg      = pmp_cfg_i[8*i +: 8];
    assign mode     = mpu_pkg::pmp_mode_e'(cfg[4:3]);
    assign addr_cur = pmp_addr_i[32*i +: 32];

    // TOR lower bound comes from the region below, region 0 starts at zero
    if (i == 0) begin : g_first
      assign addr_prev = '0;
    end else begin : g_next
      assign addr_prev = pmp_addr_i[32*(i-1) +: 32];
    end

    assign tor_match = ({addr_prev, 2'b00} <= req_addr) &&
                       (req_addr < {addr_cur, 2'b00});

    // Trailing ones plus the first zero are don't-care bits
    assign napot_mask  = ~(addr_cur ^ (addr_cur + 32'd1));
    assign napot_match = ((req_addr[33:2] ^ addr_cur) & napot_mask) == '0;

    // NA4 encoding never matches
    assign region_match[i] = ((mode == mpu_pkg::PMP_TOR) && tor_match) ||
                             ((mode == mpu_pkg::PMP_NAPOT) && napot_match);

    assign region_perm[i] = (chk.acc == mpu_pkg::PMP_ACC_READ)  ? cfg[0] :
                            (chk.acc == mpu_pkg::PMP_ACC_WRITE) ? cfg[1] :
                                                                  cfg[2];
    assign region_lock[i] = cfg[7];
  end

  // Lowest numbered match decides
  always_comb begin
    hit      = 1'b0;
    hit_perm = 1'b0;
    hit_lock = 1'b0;
    for (int i = PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (region_match[i]) begin
        hit      = 1'b1;
        hit_perm = region_perm[i];
        hit_lock = region_lock[i];
      end
    end
  end

  ////////////////////
  // Permission check
  ////////////////////

  // M mode only checked against locked regions, U mode needs a permitting match
  assign chk.pmp_err = (chk.priv_lvl == mpu_pkg::PRIV_M) ? (hit && hit_lock && !hit_perm) :
                                                           (!hit || !hit_perm);

endmodule

`default_nettype wire

//--- mpu_txn_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module mpu_txn_tracker (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic bus_req_xfer_i,
  input  wire logic bus_resp_valid_i,
  output logic      one_txn_pend_n_o
);

  // Up to three transactions in flight
  logic [1:0] cnt_q;
  logic [1:0] cnt_n;

  ////////////////////
  // Count update
  ////////////////////

  // Request and response in the same cycle cancel out
  assign cnt_n = cnt_q + {1'b0, bus_req_xfer_i} - {1'b0, bus_resp_valid_i};

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= 2'd0;
    end else begin
      cnt_q <= cnt_n;
    end
  end

  // Nothing left outstanding after this cycle
  // so a consumed error transaction is the only one pending
  assign one_txn_pend_n_o = (cnt_n == 2'd0);

endmodule

`default_nettype wire

//--- mpu_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mpu_ctrl #(
  parameter bit IF_STAGE        = 1'b0,
  parameter int PMP_NUM_REGIONS = 4
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  // Core request
  input  wire logic                          core_trans_valid_i,
  output logic                               core_trans_ready_o,
  input  wire logic [mpu_pkg::ADDR_W-1:0]    core_trans_addr_i,
  input  wire logic                          core_trans_we_i,
  input  wire logic [mpu_pkg::DATA_W-1:0]    core_trans_wdata_i,
  input  wire logic                          misaligned_access_i,
  input  wire mpu_pkg::privlvl_e             priv_lvl_i,
  // PMP CSR contents
  input  wire logic [8*PMP_NUM_REGIONS-1:0]  pmp_cfg_i,
  input  wire logic [32*PMP_NUM_REGIONS-1:0] pmp_addr_i,
  // Bus request
  input  wire logic                          bus_trans_ready_i,
  output logic                               bus_trans_valid_o,
  output logic [mpu_pkg::ADDR_W-1:0]         bus_trans_addr_o,
  output logic                               bus_trans_we_o,
  output logic [mpu_pkg::DATA_W-1:0]         bus_trans_wdata_o,
  output logic [1:0]                         bus_trans_memtype_o,
  // Bus response
  input  wire logic                          bus_resp_valid_i,
  input  wire logic [mpu_pkg::DATA_W-1:0]    bus_resp_rdata_i,
  input  wire logic                          bus_resp_err_i,
  // Core response
  output logic                               core_resp_valid_o,
  output logic [mpu_pkg::DATA_W-1:0]         core_resp_rdata_o,
  output logic                               core_resp_err_o,
  output mpu_pkg::mpu_status_e               core_resp_status_o,
  // From the tracker
  input  wire logic                          one_txn_pend_n_i
);

  mpu_pkg::mpu_state_e  state_q;
  mpu_pkg::mpu_state_e  state_n;
  mpu_pkg::mpu_status_e mpu_status;
  mpu_pkg::pmp_acc_e    acc;
  logic                 trans_we;
  logic                 mpu_err;
  logic                 block_core;
  logic                 block_bus;
  logic                 err_resp_valid;
  logic                 err_trans_ready;

  ////////////////////
  // Checkers
  ////////////////////

  mpu_check_if #(.PMP_NUM_REGIONS(PMP_NUM_REGIONS)) chk_if ();

  assign chk_if.addr       = core_trans_addr_i;
  assign chk_if.acc        = acc;
  assign chk_if.misaligned = misaligned_access_i;
  assign chk_if.priv_lvl   = priv_lvl_i;

  mpu_pma_check pma_i (
    .chk (chk_if.pma)
  );

  mpu_pmp_check #(.PMP_NUM_REGIONS(PMP_NUM_REGIONS)) pmp_i (
    .chk        (chk_if.pmp),
    .pmp_cfg_i  (pmp_cfg_i),
    .pmp_addr_i (pmp_addr_i)
  );

  assign mpu_err = chk_if.pma_err || chk_if.pmp_err;

  // Fetch side never writes
  if (IF_STAGE) begin : g_if
    assign trans_we = 1'b0;
    assign acc      = mpu_pkg::PMP_ACC_EXEC;
  end else begin : g_lsu
    assign trans_we = core_trans_we_i;
    assign acc      = core_trans_we_i ? mpu_pkg::PMP_ACC_WRITE : mpu_pkg::PMP_ACC_READ;
  end

  ////////////////////
  // Error FSM
  ////////////////////

  always_comb begin
    state_n         = state_q;
    mpu_status      = mpu_pkg::MPU_OK;
    block_core      = 1'b0;
    block_bus       = 1'b0;
    err_resp_valid  = 1'b0;
    err_trans_ready = 1'b0;
    case (state_q)
      mpu_pkg::MPU_IDLE: begin
        if (mpu_err && core_trans_valid_i) begin
          // Consume the request, keep it off the bus
          block_bus       = 1'b1;
          err_trans_ready = 1'b1;
          if (trans_we) begin
            state_n = one_txn_pend_n_i ? mpu_pkg::MPU_WR_ERR_RESP : mpu_pkg::MPU_WR_ERR_WAIT;
          end else begin
            state_n = one_txn_pend_n_i ? mpu_pkg::MPU_RE_ERR_RESP : mpu_pkg::MPU_RE_ERR_WAIT;
          end
        end
      end
      mpu_pkg::MPU_RE_ERR_WAIT, mpu_pkg::MPU_WR_ERR_WAIT: begin
        // Drain in flight transactions
        block_bus  = 1'b1;
        block_core = 1'b1;
        if (one_txn_pend_n_i) begin
          state_n = (state_q == mpu_pkg::MPU_RE_ERR_WAIT) ? mpu_pkg::MPU_RE_ERR_RESP :
                                                            mpu_pkg::MPU_WR_ERR_RESP;
        end
      end
      mpu_pkg::MPU_RE_ERR_RESP, mpu_pkg::MPU_WR_ERR_RESP: begin
        block_bus      = 1'b1;
        block_core     = 1'b1;
        err_resp_valid = 1'b1;
        mpu_status     = (state_q == mpu_pkg::MPU_RE_ERR_RESP) ? mpu_pkg::MPU_RE_FAULT :
                                                                 mpu_pkg::MPU_WR_FAULT;
        // Core always takes the response
        state_n        = mpu_pkg::MPU_IDLE;
      end
      default: begin
        state_n = mpu_pkg::MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mpu_pkg::MPU_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  ////////////////////
  // Forwarding
  ////////////////////

  assign bus_trans_valid_o   = core_trans_valid_i && !block_bus;
  assign bus_trans_addr_o    = core_trans_addr_i;
  assign bus_trans_we_o      = trans_we;
  assign bus_trans_wdata_o   = core_trans_wdata_i;
  // Bit 1 cacheable, bit 0 bufferable
  assign bus_trans_memtype_o = {chk_if.cacheable, chk_if.bufferable};

  assign core_trans_ready_o  = (bus_trans_ready_i && !block_core) || err_trans_ready;

  assign core_resp_valid_o   = bus_resp_valid_i || err_resp_valid;
  assign core_resp_rdata_o   = bus_resp_rdata_i;
  assign core_resp_err_o     = bus_resp_err_i;
  assign core_resp_status_o  = mpu_status;

endmodule

`default_nettype wire

//--- mpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module mpu_top #(
  parameter bit IF_STAGE        = 1'b0,
  parameter int PMP_NUM_REGIONS = 4
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  // Core request
  input  wire logic                          core_trans_valid_i,
  output logic                               core_trans_ready_o,
  input  wire logic [mpu_pkg::ADDR_W-1:0]    core_trans_addr_i,
  input  wire logic                          core_trans_we_i,
  input  wire logic [mpu_pkg::DATA_W-1:0]    core_trans_wdata_i,
  input  wire logic                          misaligned_access_i,
  input  wire mpu_pkg::privlvl_e             priv_lvl_i,
  // PMP CSR contents
  input  wire logic [8*PMP_NUM_REGIONS-1:0]  pmp_cfg_i,
  input  wire logic [32*PMP_NUM_REGIONS-1:0] pmp_addr_i,
  // Bus side
  input  wire logic                          bus_trans_ready_i,
  output logic                               bus_trans_valid_o,
  output logic [mpu_pkg::ADDR_W-1:0]         bus_trans_addr_o,
  output logic                               bus_trans_we_o,
  output logic [mpu_pkg::DATA_W-1:0]         bus_trans_wdata_o,
  output logic [1:0]                         bus_trans_memtype_o,
  input  wire logic                          bus_resp_valid_i,
  input  wire logic [mpu_pkg::DATA_W-1:0]    bus_resp_rdata_i,
  input  wire logic                          bus_resp_err_i,
  // Core response
  output logic                               core_resp_valid_o,
  output logic [mpu_pkg::DATA_W-1:0]         core_resp_rdata_o,
  output logic                               core_resp_err_o,
  output mpu_pkg::mpu_status_e               core_resp_status_o
);

  logic bus_req_xfer;
  logic one_txn_pend_n;

  // Request accepted by the bus this cycle
  assign bus_req_xfer = bus_trans_valid_o && bus_trans_ready_i;

  mpu_ctrl #(
    .IF_STAGE        (IF_STAGE),
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS)
  ) ctrl_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .core_trans_valid_i  (core_trans_valid_i),
    .core_trans_ready_o  (core_trans_ready_o),
    .core_trans_addr_i   (core_trans_addr_i),
    .core_trans_we_i     (core_trans_we_i),
    .core_trans_wdata_i  (core_trans_wdata_i),
    .misaligned_access_i (misaligned_access_i),
    .priv_lvl_i          (priv_lvl_i),
    .pmp_cfg_i           (pmp_cfg_i),
    .pmp_addr_i          (pmp_addr_i),
    .bus_trans_ready_i   (bus_trans_ready_i),
    .bus_trans_valid_o   (bus_trans_valid_o),
    .bus_trans_addr_o    (bus_trans_addr_o),
    .bus_trans_we_o      (bus_trans_we_o),
    .bus_trans_wdata_o   (bus_trans_wdata_o),
    .bus_trans_memtype_o (bus_trans_memtype_o),
    .bus_resp_valid_i    (bus_resp_valid_i),
    .bus_resp_rdata_i    (bus_resp_rdata_i),
    .bus_resp_err_i      (bus_resp_err_i),
    .core_resp_valid_o   (core_resp_valid_o),
    .core_resp_rdata_o   (core_resp_rdata_o),
    .core_resp_err_o     (core_resp_err_o),
    .core_resp_status_o  (core_resp_status_o),
    .one_txn_pend_n_i    (one_txn_pend_n)
  );

  // Outstanding bus transaction count
  mpu_txn_tracker tracker_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .bus_req_xfer_i   (bus_req_xfer),
    .bus_resp_valid_i (bus_resp_valid_i),
    .one_txn_pend_n_o (one_txn_pend_n)
  );

endmodule

`default_nettype wire

//--- tb_mpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mpu_top;

  localparam int NUM_PMP    = 4;
  localparam int MAX_CYCLES = 2000;
  localparam int WAIT_LIMIT = 100;

  // Request seen by the bus responder
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
    logic [31:0] due;
  } bus_req_t;

  // Response seen by the core
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  status;
    logic        err;
    logic [31:0] cyc;
  } core_resp_t;

  logic                       clk;
  logic                       rst_n;
  logic                       core_trans_valid_i;
  logic                       core_trans_ready_o;
  logic [31:0]                core_trans_addr_i;
  logic                       core_trans_we_i;
  logic [31:0]                core_trans_wdata_i;
  logic                       misaligned_access_i;
  mpu_pkg::privlvl_e          priv_lvl_i;
  logic [8*NUM_PMP-1:0]       pmp_cfg_i;
  logic [32*NUM_PMP-1:0]      pmp_addr_i;
  logic                       bus_trans_ready_i;
  logic                       bus_trans_valid_o;
  logic [31:0]                bus_trans_addr_o;
  logic                       bus_trans_we_o;
  logic [31:0]                bus_trans_wdata_o;
  logic [1:0]                 bus_trans_memtype_o;
  logic                       bus_resp_valid_i;
  logic [31:0]                bus_resp_rdata_i;
  logic                       bus_resp_err_i;
  logic                       core_resp_valid_o;
  logic [31:0]                core_resp_rdata_o;
  logic                       core_resp_err_o;
  mpu_pkg::mpu_status_e       core_resp_status_o;

  int                         cyc = 0;
  int                         err_cnt = 0;
  int                         ok_tests = 0;
  int                         fail_tests = 0;
  int                         resp_delay = 0;
  int                         bus_xfer_cnt = 0;
  int unsigned                seed_val;
  bus_req_t                   pend_q[$];
  core_resp_t                 resp_q[$];
  logic [31:0]                mem_model [logic [31:0]];
  // Bus request fields at the accepting cycle
  logic [31:0]                acc_addr;
  logic [31:0]                acc_wdata;
  logic                       acc_we;
  logic [1:0]                 acc_memtype;

  mpu_top #(.IF_STAGE(1'b0), .PMP_NUM_REGIONS(NUM_PMP)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Cycle count, also the run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////
  // Bus responder and core monitor
  ////////////////////

  // Unwritten words read back a pattern of their full address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h5ac3_e10f;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    if (mem_model.exists(addr)) begin
      return mem_model[addr];
    end
    return fill_word(addr);
  endfunction

  // Outputs sampled mid cycle where they are settled
  always @(negedge clk) begin
    if (rst_n && bus_trans_valid_o && bus_trans_ready_i) begin
      pend_q.push_back('{addr: bus_trans_addr_o, we: bus_trans_we_o,
                         wdata: bus_trans_wdata_o, due: cyc + 1 + resp_delay});
      bus_xfer_cnt++;
    end
    if (rst_n && core_resp_valid_o) begin
      resp_q.push_back('{data: core_resp_rdata_o, status: core_resp_status_o,
                         err: core_resp_err_o, cyc: cyc});
    end
  end

  // In order answers, one cycle each
  always @(posedge clk) begin : responder
    bus_req_t req;
    #1;
    bus_resp_valid_i = 1'b0;
    bus_resp_rdata_i = '0;
    if (pend_q.size() > 0 && pend_q[0].due <= cyc) begin
      req = pend_q.pop_front();
      bus_resp_valid_i = 1'b1;
      if (req.we) begin
        mem_model[req.addr] = req.wdata;
      end else begin
        bus_resp_rdata_i = model_read(req.addr);
      end
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Memory type {cacheable, bufferable} per region of the map
  function automatic logic [1:0] region_memtype(input logic [31:0] addr);
    if (addr[31:16] == 16'h0000) return 2'b11;
    if (addr[31:12] == 20'h1_0000) return 2'b01;
    if (addr[31:16] == 16'h2000) return 2'b10;
    return 2'b00;
  endfunction

  task automatic note_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("%s: ok", name);
      ok_tests++;
    end else begin
      $display("%s: FAILED with %0d errors", name, err_cnt - errs_before);
      fail_tests++;
    end
  endtask

  // Present one request and hold it until ready
  task automatic send_req(input logic [31:0] addr, input logic we, input logic [31:0] wdata,
                          input logic mis, output int wait_cyc, output int bv_wait,
                          output logic bv_acc, output int acc_cyc);
    int guard;
    @(posedge clk);
    #1;
    core_trans_valid_i  = 1'b1;
    core_trans_addr_i   = addr;
    core_trans_we_i     = we;
    core_trans_wdata_i  = wdata;
    misaligned_access_i = mis;
    wait_cyc = 0;
    bv_wait  = 0;
    guard    = 0;
    @(negedge clk);
    while (!core_trans_ready_o && guard < WAIT_LIMIT) begin
      if (bus_trans_valid_o) bv_wait++;
      wait_cyc++;
      guard++;
      @(negedge clk);
    end
    if (!core_trans_ready_o) begin
      $display("Request to %h was not accepted within %0d cycles", addr, WAIT_LIMIT);
      err_cnt++;
    end
    bv_acc      = bus_trans_valid_o;
    acc_cyc     = cyc;
    acc_addr    = bus_trans_addr_o;
    acc_wdata   = bus_trans_wdata_o;
    acc_we      = bus_trans_we_o;
    acc_memtype = bus_trans_memtype_o;
    @(posedge clk);
    #1;
    core_trans_valid_i = 1'b0;
  endtask

  task automatic wait_resp(output core_resp_t r, output bit got);
    int guard;
    guard = 0;
    while (resp_q.size() == 0 && guard < WAIT_LIMIT) begin
      @(posedge clk);
      guard++;
    end
    got = (resp_q.size() != 0);
    r   = '0;
    if (got) begin
      r = resp_q.pop_front();
    end else begin
      $display("No core response arrived within %0d cycles", WAIT_LIMIT);
      err_cnt++;
    end
  endtask

  // Passing access, straight to the bus and back with OK
  task automatic expect_ok(input logic [31:0] addr, input logic we, input logic [31:0] wdata);
    int          wait_cyc;
    int          bv_wait;
    int          acc_cyc;
    logic        bv_acc;
    core_resp_t  r;
    bit          got;
    logic [31:0] exp_data;
    exp_data = model_read(addr);
    send_req(addr, we, wdata, 1'b0, wait_cyc, bv_wait, bv_acc, acc_cyc);
    if (wait_cyc != 0 || !bv_acc)
      note_error($sformatf("access to %h did not reach the bus at once", addr));
    if (acc_addr != addr || acc_we != we || acc_wdata != wdata)
      note_error($sformatf("bus got %h/%b/%h, expected %h/%b/%h",
                           acc_addr, acc_we, acc_wdata, addr, we, wdata));
    if (acc_memtype != region_memtype(addr))
      note_error($sformatf("memtype %b for %h, expected %b",
                           acc_memtype, addr, region_memtype(addr)));
    wait_resp(r, got);
    if (got && (r.status != mpu_pkg::MPU_OK || r.err))
      note_error($sformatf("access to %h returned status %0d err %b", addr, r.status, r.err));
    if (got && !we && r.data != exp_data)
      note_error($sformatf("read %h returned %h, expected %h", addr, r.data, exp_data));
  endtask

  // Failing access with nothing outstanding
  task automatic expect_fault(input logic [31:0] addr, input logic we, input logic mis,
                              input logic [1:0] exp_status);
    int         wait_cyc;
    int         bv_wait;
    int         acc_cyc;
    int         xfer_before;
    logic       bv_acc;
    core_resp_t r;
    bit         got;
    xfer_before = bus_xfer_cnt;
    send_req(addr, we, $urandom, mis, wait_cyc, bv_wait, bv_acc, acc_cyc);
    if (wait_cyc != 0)
      note_error($sformatf("failing access to %h waited %0d cycles", addr, wait_cyc));
    if (bv_acc)
      note_error($sformatf("failing access to %h raised bus valid", addr));
    wait_resp(r, got);
    if (got && r.status != exp_status)
      note_error($sformatf("access to %h gave status %0d, expected %0d",
                           addr, r.status, exp_status));
    if (got && r.cyc != acc_cyc + 1)
      note_error($sformatf("fault in cycle %0d, expected %0d", r.cyc, acc_cyc + 1));
    if (bus_xfer_cnt != xfer_before)
      note_error($sformatf("failing access to %h was sent to the bus", addr));
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic reset_state();
    int errs;
    errs = err_cnt;
    @(negedge clk);
    if (bus_trans_valid_o || core_resp_valid_o || core_trans_ready_o)
      note_error($sformatf("after reset bus valid %b resp valid %b ready %b",
                           bus_trans_valid_o, core_resp_valid_o, core_trans_ready_o));
    @(posedge clk);
    #1;
    bus_trans_ready_i = 1'b1;
    report_test("reset_state", errs);
  endtask

  task automatic passing_access();
    int          errs;
    logic [31:0] ram_addr;
    logic [31:0] io_addr;
    errs     = err_cnt;
    ram_addr = $urandom & 32'h0000_fffc;
    io_addr  = 32'h1000_0000 | ($urandom & 32'h0000_0ffc);
    expect_ok(ram_addr, 1'b1, $urandom);
    expect_ok(ram_addr, 1'b0, 32'h0);
    expect_ok(io_addr, 1'b1, $urandom);
    expect_ok(io_addr, 1'b0, 32'h0);
    expect_ok(32'h2000_0000 | ($urandom & 32'h0000_fffc), 1'b0, 32'h0);
    report_test("passing_access", errs);
  endtask

  task automatic pma_faults();
    int errs;
    errs = err_cnt;
    // ROM write, unmapped read, misaligned I/O read and write
    expect_fault(32'h2000_0000 | ($urandom & 32'h0000_fffc), 1'b1, 1'b0, mpu_pkg::MPU_WR_FAULT);
    expect_fault(32'h3000_0000 | ($urandom & 32'h0000_fffc), 1'b0, 1'b0, mpu_pkg::MPU_RE_FAULT);
    expect_fault(32'h1000_0002, 1'b0, 1'b1, mpu_pkg::MPU_RE_FAULT);
    expect_fault(32'h1000_0101, 1'b1, 1'b1, mpu_pkg::MPU_WR_FAULT);
    report_test("pma_faults", errs);
  endtask

  task automatic pmp_rules();
    int          errs;
    logic [31:0] low_addr;
    logic [31:0] io_addr;
    errs     = err_cnt;
    low_addr = $urandom & 32'h0000_7ffc;
    io_addr  = 32'h1000_0000 | ($urandom & 32'h0000_0ffc);
    // User mode, region 0 TOR up to 0x8000, read only
    @(posedge clk);
    #1;
    priv_lvl_i = mpu_pkg::PRIV_U;
    pmp_cfg_i  = {24'h0, 8'h09};
    pmp_addr_i = {96'h0, 32'h0000_2000};
    expect_ok(low_addr, 1'b0, 32'h0);
    expect_fault(low_addr, 1'b1, 1'b0, mpu_pkg::MPU_WR_FAULT);
    // Above the TOR top nothing matches
    expect_fault(32'h0000_8000 | ($urandom & 32'h0000_7ffc), 1'b0, 1'b0, mpu_pkg::MPU_RE_FAULT);
    // Machine mode, locked NAPOT over the 4 KiB I/O block, read only
    @(posedge clk);
    #1;
    priv_lvl_i = mpu_pkg::PRIV_M;
    pmp_cfg_i  = {24'h0, 8'h99};
    pmp_addr_i = {96'h0, 32'h0400_01ff};
    expect_fault(io_addr, 1'b1, 1'b0, mpu_pkg::MPU_WR_FAULT);
    expect_ok(io_addr, 1'b0, 32'h0);
    expect_ok(low_addr, 1'b1, $urandom);
    @(posedge clk);
    #1;
    pmp_cfg_i  = '0;
    pmp_addr_i = '0;
    report_test("pmp_rules", errs);
  endtask

  task automatic drain_on_fault();
    int          errs;
    int          wait_cyc;
    int          bv_wait;
    int          acc_cyc;
    int          fail_acc;
    logic        bv_acc;
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    core_resp_t  r1;
    core_resp_t  r2;
    core_resp_t  rf;
    core_resp_t  r4;
    bit          got;
    errs   = err_cnt;
    addr_a = $urandom & 32'h0000_fffc;
    addr_b = $urandom & 32'h0000_fffc;
    resp_delay = 6;
    send_req(addr_a, 1'b0, 32'h0, 1'b0, wait_cyc, bv_wait, bv_acc, acc_cyc);
    send_req(addr_b, 1'b0, 32'h0, 1'b0, wait_cyc, bv_wait, bv_acc, acc_cyc);
    // Failing read while both reads are in flight
    send_req(32'h3000_0010, 1'b0, 32'h0, 1'b0, wait_cyc, bv_wait, bv_acc, fail_acc);
    if (wait_cyc != 0 || bv_acc)
      note_error($sformatf("failing access waited %0d cycles, bus valid %b", wait_cyc, bv_acc));
    // Next passing request stalls until the FSM is back in idle
    send_req(addr_a, 1'b0, 32'h0, 1'b0, wait_cyc, bv_wait, bv_acc, acc_cyc);
    if (wait_cyc == 0 || bv_wait != 0)
      note_error($sformatf("blocked request waited %0d cycles, %0d with bus valid",
                           wait_cyc, bv_wait));
    if (!bv_acc)
      note_error("request after the fault did not reach the bus");
    wait_resp(r1, got);
    wait_resp(r2, got);
    wait_resp(rf, got);
    wait_resp(r4, got);
    if (r1.status != mpu_pkg::MPU_OK || r1.data != model_read(addr_a))
      note_error($sformatf("first read gave %h status %0d", r1.data, r1.status));
    if (r2.status != mpu_pkg::MPU_OK || r2.data != model_read(addr_b))
      note_error($sformatf("second read gave %h status %0d", r2.data, r2.status));
    if (r2.cyc <= fail_acc) begin
      $display("Setup problem: reads finished before the fault was accepted");
      err_cnt++;
    end
    if (rf.status != mpu_pkg::MPU_RE_FAULT || rf.cyc != r2.cyc + 1)
      note_error($sformatf("fault status %0d in cycle %0d, expected %0d in cycle %0d",
                           rf.status, rf.cyc, mpu_pkg::MPU_RE_FAULT, r2.cyc + 1));
    if (acc_cyc != rf.cyc + 1)
      note_error($sformatf("next request accepted in cycle %0d, expected %0d",
                           acc_cyc, rf.cyc + 1));
    if (r4.status != mpu_pkg::MPU_OK)
      note_error($sformatf("read after the fault gave status %0d", r4.status));
    resp_delay = 0;
    report_test("drain_on_fault", errs);
  endtask

  task automatic bus_backpressure();
    int          errs;
    int          wait_cyc;
    int          bv_wait;
    int          acc_cyc;
    logic        bv_acc;
    logic [31:0] addr;
    core_resp_t  r;
    bit          got;
    errs = err_cnt;
    addr = $urandom & 32'h0000_fffc;
    @(posedge clk);
    #1;
    bus_trans_ready_i = 1'b0;
    fork
      send_req(addr, 1'b0, 32'h0, 1'b0, wait_cyc, bv_wait, bv_acc, acc_cyc);
      begin
        repeat (3) @(posedge clk);
        #1;
        bus_trans_ready_i = 1'b1;
      end
    join
    if (wait_cyc == 0 || bv_wait != wait_cyc || !bv_acc)
      note_error($sformatf("stalled request waited %0d cycles, %0d with bus valid",
                           wait_cyc, bv_wait));
    wait_resp(r, got);
    if (got && (r.status != mpu_pkg::MPU_OK || r.data != model_read(addr)))
      note_error($sformatf("stalled read gave %h status %0d", r.data, r.status));
    // Fault is taken even with the bus stalled
    @(posedge clk);
    #1;
    bus_trans_ready_i = 1'b0;
    expect_fault(32'h3000_0020, 1'b1, 1'b0, mpu_pkg::MPU_WR_FAULT);
    @(posedge clk);
    #1;
    bus_trans_ready_i = 1'b1;
    report_test("bus_backpressure", errs);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    seed_val            = $urandom(32'h0a3f3bfb);
    rst_n               = 1'b0;
    core_trans_valid_i  = 1'b0;
    core_trans_addr_i   = '0;
    core_trans_we_i     = 1'b0;
    core_trans_wdata_i  = '0;
    misaligned_access_i = 1'b0;
    priv_lvl_i          = mpu_pkg::PRIV_M;
    pmp_cfg_i           = '0;
    pmp_addr_i          = '0;
    bus_trans_ready_i   = 1'b0;
    bus_resp_valid_i    = 1'b0;
    bus_resp_rdata_i    = '0;
    bus_resp_err_i      = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    reset_state();
    passing_access();
    pma_faults();
    pmp_rules();
    drain_on_fault();
    bus_backpressure();
    $display("Summary: %0d tests ok, %0d tests failed, %0d errors",
             ok_tests, fail_tests, err_cnt);
    if (fail_tests == 0 && err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
mpu_pkg.sv
mpu_check_if.sv
mpu_pma_check.sv
mpu_pmp_check.sv
mpu_txn_tracker.sv
mpu_ctrl.sv
mpu_top.sv
tb_mpu_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_mpu_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
